/* all.f */
+incdir+include
source/h_load_pkg.sv
source/h_load_ctrl.sv
source/h_addr_counter.sv
source/h_row_offset.sv
source/h_row_fifo.sv
source/h_loader_top.sv
test/h_loader_properties.sv
test/h_loader_checker.sv
test/h_loader_tb.sv

/* include/h_load_cfg.svh */
`ifndef H_LOAD_CFG_SVH
`define H_LOAD_CFG_SVH

// rows of H, one per graph node
`define H_NUM_ROWS 4

// feature columns per row
`define H_NUM_COLS 16

// width of one nonzero value
`define H_VALUE_W 8

// upper bound on nonzeros in one load
`define H_NNZ_MAX 16

// entries per row FIFO
`define H_FIFO_DEPTH 4

// RAM address width, covers length words plus entries
`define H_ADDR_W 6

`endif

/* run_sim.sh */
#!/bin/sh
# Build and run the sparse H loader testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f all.f --top-module h_loader_tb -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/Vh_loader_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "sim passed"; then
  exit 0
fi
exit 1

/* source/h_addr_counter.sv */
`default_nettype none

`include "h_load_cfg.svh"

module h_addr_counter (
  input  wire logic                 clk,
  input  wire logic                 rst_n,
  input  wire logic                 clear_i,
  input  wire logic                 step_i,
  input  wire logic                 ent_phase_i,
  input  wire h_load_pkg::row_len_t total_nnz_i,
  output logic [`H_ADDR_W-1:0]      addr_o,
  output h_load_pkg::row_len_t      ent_idx_o,
  output logic                      len_last_o,
  output logic                      ent_last_o
);

  h_load_pkg::row_id_t  row_idx_q;
  h_load_pkg::row_len_t ent_idx_q;

  always_ff @(posedge clk) begin
    if (!rst_n || clear_i) begin
      row_idx_q <= '0;
      ent_idx_q <= '0;
    end else if (step_i) begin
      if (ent_phase_i) begin
        ent_idx_q <= ent_idx_q + 1'b1;
      end else begin
        row_idx_q <= row_idx_q + 1'b1;
      end
    end
  end

  // length words first, entries packed right behind them
  assign addr_o = ent_phase_i ? (`H_ADDR_W'(`H_NUM_ROWS) + `H_ADDR_W'(ent_idx_q))
                              : `H_ADDR_W'(row_idx_q);

  assign ent_idx_o = ent_idx_q;

  assign len_last_o = (row_idx_q == h_load_pkg::row_id_t'(`H_NUM_ROWS - 1));

  // only looked at when total is nonzero
  assign ent_last_o = (ent_idx_q == h_load_pkg::row_len_t'(total_nnz_i - 1'b1));

endmodule

`default_nettype wire

/* source/h_load_ctrl.sv */
`default_nettype none

`include "h_load_cfg.svh"

module h_load_ctrl (
  input  wire logic                 clk,
  input  wire logic                 rst_n,
  input  wire logic                 start_i,
  input  wire logic                 len_last_i,
  input  wire logic                 ent_last_i,
  input  wire logic                 nnz_zero_i,
  input  wire h_load_pkg::row_id_t  next_row_i,
  input  wire h_load_pkg::row_len_t fifo_count_i [`H_NUM_ROWS],
  output logic                      cnt_clear_o,
  output logic                      cnt_step_o,
  output logic                      ent_phase_o,
  output logic                      len_valid_o,
  output logic                      fifo_clear_o,
  output logic [`H_NUM_ROWS-1:0]    fifo_push_o,
  output logic                      bram_en_o,
  output logic                      ready_o
);

  h_load_pkg::h_load_state_t state_q;
  h_load_pkg::h_load_state_t state_d;
  logic                      en_q;
  logic                      ent_q;
  h_load_pkg::row_id_t       pend_row_q;
  logic                      start_ok;
  logic                      pending;
  logic                      stall;

  // start only counts between loads
  assign start_ok = start_i &&
                    (state_q == h_load_pkg::IDLE || state_q == h_load_pkg::READY);

  // word returning this cycle headed for the same row
  assign pending = en_q && ent_q && (pend_row_q == next_row_i);
  assign stall = (fifo_count_i[next_row_i] + h_load_pkg::row_len_t'(pending))
                 >= `H_FIFO_DEPTH;

  assign ent_phase_o  = (state_q == h_load_pkg::ENT_READ);
  assign bram_en_o    = (state_q == h_load_pkg::LEN_READ) || (ent_phase_o && !stall);
  assign cnt_step_o   = bram_en_o;
  assign cnt_clear_o  = start_ok;
  assign fifo_clear_o = start_ok;
  assign len_valid_o  = en_q && !ent_q;
  assign ready_o      = (state_q == h_load_pkg::READY);

  always_comb begin
    for (int r = 0; r < `H_NUM_ROWS; r++) begin
      fifo_push_o[r] = en_q && ent_q && (pend_row_q == h_load_pkg::row_id_t'(r));
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      h_load_pkg::IDLE,
      h_load_pkg::READY: if (start_ok) state_d = h_load_pkg::LEN_READ;
      h_load_pkg::LEN_READ: if (len_last_i) state_d = h_load_pkg::LEN_DRAIN;
      // last length word is summed this cycle
      h_load_pkg::LEN_DRAIN: begin
        state_d = nnz_zero_i ? h_load_pkg::READY : h_load_pkg::ENT_READ;
      end
      h_load_pkg::ENT_READ: if (!stall && ent_last_i) state_d = h_load_pkg::ENT_DRAIN;
      h_load_pkg::ENT_DRAIN: state_d = h_load_pkg::READY;
      default: state_d = h_load_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= h_load_pkg::IDLE;
      en_q    <= 1'b0;
      ent_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      en_q    <= bram_en_o;
      ent_q   <= ent_phase_o;
    end
  end

  // row of the read in flight
  always_ff @(posedge clk) begin
    if (bram_en_o && ent_phase_o) begin
      pend_row_q <= next_row_i;
    end
  end

endmodule

`default_nettype wire

/* source/h_load_pkg.sv */
`default_nettype none

`include "h_load_cfg.svh"

package h_load_pkg;

  // feature column index
  typedef logic [$clog2(`H_NUM_COLS)-1:0] col_idx_t;

  // nonzero value, carried as raw bits
  typedef logic [`H_VALUE_W-1:0] value_t;

  // row length or offset, wide enough for H_NNZ_MAX itself
  typedef logic [$clog2(`H_NNZ_MAX+1)-1:0] row_len_t;

  // row number
  typedef logic [$clog2(`H_NUM_ROWS)-1:0] row_id_t;

  // one nonzero as stored in a row FIFO
  typedef struct packed {
    col_idx_t col_idx;
    value_t   value;
  } h_entry_t;

  // RAM word; a length word sits in the low bits
  typedef struct packed {
    h_entry_t entry;
  } h_bram_word_t;

  typedef enum logic [2:0] {
    IDLE,
    LEN_READ,
    LEN_DRAIN,
    ENT_READ,
    ENT_DRAIN,
    READY
  } h_load_state_t;

endpackage

`default_nettype wire

/* source/h_loader_top.sv */
`default_nettype none

`include "h_load_cfg.svh"

module h_loader_top (
  input  wire logic                     clk,
  input  wire logic                     rst_n,
  input  wire logic                     start_i,
  input  wire h_load_pkg::h_bram_word_t h_bram_dout_i,
  output logic                          h_bram_en_o,
  output logic [`H_ADDR_W-1:0]          h_bram_addr_o,
  input  wire logic [`H_NUM_ROWS-1:0]   h_pop_i,
  output logic [`H_NUM_ROWS-1:0]        h_valid_o,
  output h_load_pkg::h_entry_t          h_data_o [`H_NUM_ROWS],
  output logic                          h_ready_o
);

  logic                         cnt_clear;
  logic                         cnt_step;
  logic                         ent_phase;
  logic                         len_valid;
  logic                         fifo_clear;
  logic [`H_NUM_ROWS-1:0]       fifo_push;
  logic                         len_last;
  logic                         ent_last;
  logic                         nnz_zero;
  h_load_pkg::row_len_t         ent_idx;
  h_load_pkg::row_len_t         total_nnz;
  h_load_pkg::row_id_t          issue_row;
  h_load_pkg::row_len_t         fifo_count [`H_NUM_ROWS];

  h_load_ctrl u_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .start_i      (start_i),
    .len_last_i   (len_last),
    .ent_last_i   (ent_last),
    .nnz_zero_i   (nnz_zero),
    .next_row_i   (issue_row),
    .fifo_count_i (fifo_count),
    .cnt_clear_o  (cnt_clear),
    .cnt_step_o   (cnt_step),
    .ent_phase_o  (ent_phase),
    .len_valid_o  (len_valid),
    .fifo_clear_o (fifo_clear),
    .fifo_push_o  (fifo_push),
    .bram_en_o    (h_bram_en_o),
    .ready_o      (h_ready_o)
  );

  h_addr_counter u_counter (
    .clk         (clk),
    .rst_n       (rst_n),
    .clear_i     (cnt_clear),
    .step_i      (cnt_step),
    .ent_phase_i (ent_phase),
    .total_nnz_i (total_nnz),
    .addr_o      (h_bram_addr_o),
    .ent_idx_o   (ent_idx),
    .len_last_o  (len_last),
    .ent_last_o  (ent_last)
  );

  // length word read from the low bits of the RAM word
  h_row_offset u_offset (
    .clk         (clk),
    .rst_n       (rst_n),
    .clear_i     (cnt_clear),
    .len_valid_i (len_valid),
    .len_i       (h_bram_dout_i[$bits(h_load_pkg::row_len_t)-1:0]),
    .issue_idx_i (ent_idx),
    .issue_row_o (issue_row),
    .total_nnz_o (total_nnz),
    .nnz_zero_o  (nnz_zero)
  );

  for (genvar gi = 0; gi < `H_NUM_ROWS; gi++) begin : g_row
    h_row_fifo u_fifo (
      .clk     (clk),
      .rst_n   (rst_n),
      .clear_i (fifo_clear),
      .push_i  (fifo_push[gi]),
      .pop_i   (h_pop_i[gi]),
      .data_i  (h_bram_dout_i.entry),
      .data_o  (h_data_o[gi]),
      .valid_o (h_valid_o[gi]),
      .count_o (fifo_count[gi])
    );
  end

endmodule

`default_nettype wire

/* source/h_row_fifo.sv */
`default_nettype none

`include "h_load_cfg.svh"

module h_row_fifo (
  input  wire logic                 clk,
  input  wire logic                 rst_n,
  input  wire logic                 clear_i,
  input  wire logic                 push_i,
  input  wire logic                 pop_i,
  input  wire h_load_pkg::h_entry_t data_i,
  output h_load_pkg::h_entry_t      data_o,
  output logic                      valid_o,
  output h_load_pkg::row_len_t      count_o
);

  localparam int PTR_W = $clog2(`H_FIFO_DEPTH);

  h_load_pkg::h_entry_t mem [`H_FIFO_DEPTH];
  logic [PTR_W-1:0]     rd_ptr_q;
  logic [PTR_W-1:0]     wr_ptr_q;
  h_load_pkg::row_len_t count_q;
  logic                 do_pop;

  // pop on an empty FIFO is dropped
  assign do_pop = pop_i && (count_q != '0);

  always_ff @(posedge clk) begin
    if (!rst_n || clear_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(`H_FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(`H_FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + h_load_pkg::row_len_t'(push_i)
                         - h_load_pkg::row_len_t'(do_pop);
    end
  end

  always_ff @(posedge clk) begin
    if (push_i) begin
      mem[wr_ptr_q] <= data_i;
    end
  end

  // head shows without a read cycle
  assign data_o  = mem[rd_ptr_q];
  assign valid_o = (count_q != '0);
  assign count_o = count_q;

endmodule

`default_nettype wire

/* source/h_row_offset.sv */
`default_nettype none

`include "h_load_cfg.svh"

module h_row_offset (
  input  wire logic                 clk,
  input  wire logic                 rst_n,
  input  wire logic                 clear_i,
  input  wire logic                 len_valid_i,
  input  wire h_load_pkg::row_len_t len_i,
  input  wire h_load_pkg::row_len_t issue_idx_i,
  output h_load_pkg::row_id_t       issue_row_o,
  output h_load_pkg::row_len_t      total_nnz_o,
  output logic                      nnz_zero_o
);

  h_load_pkg::row_len_t end_off_q [`H_NUM_ROWS];
  h_load_pkg::row_len_t sum_q;
  h_load_pkg::row_len_t sum_d;
  h_load_pkg::row_id_t  len_idx_q;

  assign sum_d = sum_q + (len_valid_i ? len_i : '0);

  always_ff @(posedge clk) begin
    if (!rst_n || clear_i) begin
      sum_q     <= '0;
      len_idx_q <= '0;
    end else if (len_valid_i) begin
      sum_q     <= sum_d;
      len_idx_q <= len_idx_q + 1'b1;
    end
  end

  // end offset of each row, rewritten every load
  always_ff @(posedge clk) begin
    if (len_valid_i) begin
      end_off_q[len_idx_q] <= sum_d;
    end
  end

  assign total_nnz_o = sum_q;

  // includes the word arriving now, so valid in the drain cycle
  assign nnz_zero_o = (sum_d == '0);

  // first row whose end offset is past the index
  always_comb begin
    issue_row_o = h_load_pkg::row_id_t'(`H_NUM_ROWS - 1);
    for (int r = `H_NUM_ROWS - 1; r >= 0; r--) begin
      if (end_off_q[r] > issue_idx_i) begin
        issue_row_o = h_load_pkg::row_id_t'(r);
      end
    end
  end

endmodule

`default_nettype wire

/* test/h_loader_checker.sv */
`default_nettype none

`include "h_load_cfg.svh"

module h_loader_checker (
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  input  wire logic                   new_load_i,
  input  wire logic                   load_end_i,
  input  wire h_load_pkg::row_len_t   exp_len_i [`H_NUM_ROWS],
  input  wire h_load_pkg::h_entry_t   exp_ent_i [`H_NNZ_MAX],
  input  wire logic                   bram_en_i,
  input  wire logic [`H_ADDR_W-1:0]   bram_addr_i,
  input  wire logic [`H_NUM_ROWS-1:0] pop_i,
  input  wire logic [`H_NUM_ROWS-1:0] valid_i,
  input  wire h_load_pkg::h_entry_t   data_i [`H_NUM_ROWS],
  input  wire logic                   ready_i,
  output int                          data_errs_o,
  output int                          addr_errs_o,
  output int                          ready_errs_o
);

  h_load_pkg::h_entry_t exp_q [`H_NUM_ROWS][$];
  int                   row_len [`H_NUM_ROWS];
  int                   total;
  int                   exp_addr;
  int                   ent_reads;
  int                   popped;
  int                   cyc;
  int                   last_read_cyc;
  logic                 in_load;
  logic                 ready_q;

  initial begin
    data_errs_o  = 0;
    addr_errs_o  = 0;
    ready_errs_o = 0;
    in_load      = 1'b0;
    ready_q      = 1'b0;
    cyc          = 0;
    total        = 0;
    for (int r = 0; r < `H_NUM_ROWS; r++) row_len[r] = 0;
  end

  always @(posedge clk) begin
    int idx;
    h_load_pkg::h_entry_t head;
    cyc++;
    if (rst_n) begin
      // expected queues come straight from storage order
      if (new_load_i) begin
        idx = 0;
        total = 0;
        for (int r = 0; r < `H_NUM_ROWS; r++) begin
          exp_q[r].delete();
          row_len[r] = int'(exp_len_i[r]);
          for (int k = 0; k < row_len[r]; k++) begin
            exp_q[r].push_back(exp_ent_i[idx]);
            idx++;
          end
          total += row_len[r];
        end
        exp_addr = 0;
        ent_reads = 0;
        popped = 0;
        in_load = 1'b1;
      end
      if (bram_en_i) begin
        if (!in_load || exp_addr >= `H_NUM_ROWS + total) begin
          $display("%0t: RAM read at address %0d outside the current load", $time, bram_addr_i);
          addr_errs_o++;
        end else if (int'(bram_addr_i) != exp_addr) begin
          $display("[ERROR] %0t h_bram_addr_o got %0d expected %0d",
                   $time, bram_addr_i, exp_addr);
          addr_errs_o++;
        end
        if (int'(bram_addr_i) >= `H_NUM_ROWS) begin
          ent_reads++;
          last_read_cyc = cyc;
        end
        exp_addr++;
      end
      for (int r = 0; r < `H_NUM_ROWS; r++) begin
        if (valid_i[r] && row_len[r] == 0) begin
          $display("%0t: row %0d has length zero but shows valid data", $time, r);
          data_errs_o++;
        end
        if (pop_i[r] && valid_i[r]) begin
          if (exp_q[r].size() == 0) begin
            $display("%0t: row %0d popped an entry that was never stored", $time, r);
            data_errs_o++;
          end else begin
            head = exp_q[r].pop_front();
            if (data_i[r] !== head) begin
              $display("[ERROR] %0t h_data_o[%0d] got %h expected %h",
                       $time, r, data_i[r], head);
              data_errs_o++;
            end
          end
          popped++;
        end
      end
      // ready must follow the last entry write
      if (ready_i && !ready_q) begin
        if (exp_addr != `H_NUM_ROWS + total || ent_reads != total) begin
          $display("%0t: ready rose after %0d of %0d entry reads", $time, ent_reads, total);
          ready_errs_o++;
        end
        if (total > 0 && cyc - last_read_cyc < 2) begin
          $display("%0t: ready rose before the last entry was written", $time);
          ready_errs_o++;
        end
      end
      if (load_end_i) begin
        if (popped != total || valid_i != '0) begin
          $display("%0t: load ended with %0d of %0d entries popped", $time, popped, total);
          data_errs_o++;
        end
        in_load = 1'b0;
      end
      ready_q = ready_i;
    end
  end

endmodule

`default_nettype wire

/* test/h_loader_properties.sv */
`default_nettype none

`include "h_load_cfg.svh"

module h_loader_properties (
  input wire logic                   clk,
  input wire logic                   rst_n,
  input wire logic                   start_i,
  input wire logic                   ready_o,
  input wire logic [`H_NUM_ROWS-1:0] fifo_push_o,
  input wire h_load_pkg::row_len_t   fifo_count_i [`H_NUM_ROWS]
);

  // ready is a level that only a new start clears
  a_ready_holds: assert property (@(posedge clk) disable iff (!rst_n)
    (ready_o && !start_i) |=> ready_o)
    else $error("ready dropped with no start");

  // a start ends the ready level
  a_ready_falls: assert property (@(posedge clk) disable iff (!rst_n)
    (ready_o && start_i) |=> !ready_o)
    else $error("ready stayed high after a start");

  for (genvar gr = 0; gr < `H_NUM_ROWS; gr++) begin : g_full
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
      fifo_push_o[gr] |-> (fifo_count_i[gr] < `H_FIFO_DEPTH))
      else $error("push into full row FIFO %0d", gr);
  end

endmodule

bind h_load_ctrl h_loader_properties u_props (
  .clk          (clk),
  .rst_n        (rst_n),
  .start_i      (start_i),
  .ready_o      (ready_o),
  .fifo_push_o  (fifo_push_o),
  .fifo_count_i (fifo_count_i)
);

`default_nettype wire

/* test/h_loader_tb.sv */
`default_nettype none

`include "h_load_cfg.svh"

module h_loader_tb;

  localparam int NUM_LOADS = 8;
  localparam int RAM_SIZE  = 1 << `H_ADDR_W;

  logic                       clk;
  logic                       rst_n;
  logic                       start;
  logic                       new_load;
  logic                       load_end;
  logic [`H_NUM_ROWS-1:0]     pop;
  logic [`H_NUM_ROWS-1:0]     valid;
  logic                       ready;
  logic                       bram_en;
  logic [`H_ADDR_W-1:0]       bram_addr;
  h_load_pkg::h_bram_word_t   bram_dout;
  h_load_pkg::h_entry_t       data [`H_NUM_ROWS];
  h_load_pkg::h_bram_word_t   ram [RAM_SIZE];
  h_load_pkg::row_len_t       exp_len [`H_NUM_ROWS];
  h_load_pkg::h_entry_t       exp_ent [`H_NNZ_MAX];
  logic [31:0]                rng;
  int                         data_errs;
  int                         addr_errs;
  int                         ready_errs;

  always #2 clk = ~clk;

  h_loader_top uut (
    .clk           (clk),
    .rst_n         (rst_n),
    .start_i       (start),
    .h_bram_dout_i (bram_dout),
    .h_bram_en_o   (bram_en),
    .h_bram_addr_o (bram_addr),
    .h_pop_i       (pop),
    .h_valid_o     (valid),
    .h_data_o      (data),
    .h_ready_o     (ready)
  );

  // one-cycle read latency
  always @(posedge clk) begin
    if (bram_en) bram_dout <= ram[bram_addr];
  end

  h_loader_checker chk (
    .clk          (clk),
    .rst_n        (rst_n),
    .new_load_i   (new_load),
    .load_end_i   (load_end),
    .exp_len_i    (exp_len),
    .exp_ent_i    (exp_ent),
    .bram_en_i    (bram_en),
    .bram_addr_i  (bram_addr),
    .pop_i        (pop),
    .valid_i      (valid),
    .data_i       (data),
    .ready_i      (ready),
    .data_errs_o  (data_errs),
    .addr_errs_o  (addr_errs),
    .ready_errs_o (ready_errs)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic draw(output logic [31:0] v);
    rng = xorshift32(rng);
    v = rng;
  endtask

  // each row bit about half the time
  task automatic random_pops();
    logic [31:0] v;
    draw(v);
    pop = v[`H_NUM_ROWS-1:0];
  endtask

  task automatic build_matrix(input bit all_zero);
    logic [31:0] v;
    int          n;
    n = 0;
    for (int a = 0; a < RAM_SIZE; a++) begin
      ram[a] = h_load_pkg::h_bram_word_t'(12'(a * 37) ^ 12'ha5c);
    end
    for (int r = 0; r < `H_NUM_ROWS; r++) begin
      draw(v);
      exp_len[r] = all_zero ? '0 : h_load_pkg::row_len_t'(v % 5);
      ram[r] = h_load_pkg::h_bram_word_t'(exp_len[r]);
      n += int'(exp_len[r]);
    end
    for (int i = 0; i < `H_NNZ_MAX; i++) begin
      draw(v);
      exp_ent[i] = h_load_pkg::h_entry_t'(v[11:0]);
      if (i < n) ram[`H_NUM_ROWS + i] = h_load_pkg::h_bram_word_t'(exp_ent[i]);
    end
  endtask

  initial begin
    repeat (16 + NUM_LOADS * 200) @(posedge clk);
    $display("watchdog expired before all loads finished");
    $display("sim failed");
    $finish;
  end

  initial begin
    logic [31:0] v;
    int          wait_cyc;
    int          n_cyc;
    clk = 1'b0;
    rst_n = 1'b0;
    start = 1'b0;
    new_load = 1'b0;
    load_end = 1'b0;
    pop = '0;
    bram_dout = '0;
    rng = 32'd13073;
    for (int r = 0; r < `H_NUM_ROWS; r++) exp_len[r] = '0;
    for (int i = 0; i < `H_NNZ_MAX; i++) exp_ent[i] = '0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    for (int ld = 0; ld < NUM_LOADS; ld++) begin
      build_matrix(ld == 1);
      draw(v);
      wait_cyc = int'(v % 8);
      repeat (wait_cyc) @(negedge clk);
      pop = '0;
      start = 1'b1;
      new_load = 1'b1;
      @(negedge clk);
      start = 1'b0;
      new_load = 1'b0;
      n_cyc = 0;
      while (!ready) begin
        random_pops();
        // a start in mid load must be ignored
        start = (n_cyc == 3);
        n_cyc++;
        @(negedge clk);
      end
      start = 1'b0;
      while (valid != '0) begin
        random_pops();
        @(negedge clk);
      end
      pop = '0;
      load_end = 1'b1;
      @(negedge clk);
      load_end = 1'b0;
    end
    repeat (4) @(negedge clk);
    $display("errors: data %0d, address %0d, ready %0d", data_errs, addr_errs, ready_errs);
    if (data_errs + addr_errs + ready_errs == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
